//--- verilog/qs_mem_pkg.sv
/*
 * Queue storage array types
 * Address, stored word and payload widths of the 128x35 register file,
 * plus the structs that carry one write or one read request to it
 */

package qs_mem_pkg;

    // Number of words in the shared array
    localparam int RF_DEPTH = 128;

    // Position of the even-parity bit inside a stored word
    localparam int PARITY_BIT = 34;

    // Array address, queue id on top and slot below
    typedef logic [6:0] rf_addr_t;

    // One stored word, parity in bit 34 and payload in bits 33 to 0
    typedef logic [34:0] rf_word_t;

    // Payload as seen on the queue ports
    typedef logic [33:0] payload_t;

    // Write port request
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
        rf_word_t data;
    } rf_wr_t;

    // Read port request, data comes back one cycle later
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
    } rf_rd_t;

endpackage

//--- verilog/qs_queue_pkg.sv
/*
 * Queue level types
 * Queue id, wrap-bit pointers and geometry of the four hardware queues,
 * and the command and response structs of the queue and debug ports
 */

package qs_queue_pkg;

    import qs_mem_pkg::*;

    // Four queues of 32 entries share the 128-word array
    localparam int NUM_QUEUES  = 4;
    localparam int QUEUE_DEPTH = 32;
    localparam int SLOT_W      = 5;

    typedef logic [1:0] qid_t;

    // Slot in the low five bits, wrap bit on top to tell full from empty
    typedef logic [5:0] qptr_t;

    typedef struct packed {
        logic     valid;
        qid_t     qid;
        payload_t payload;
    } enq_cmd_t;

    typedef struct packed {
        logic valid;
        qid_t qid;
    } deq_cmd_t;

    // Empty and perr are only meaningful while valid is high
    typedef struct packed {
        logic     valid;
        logic     empty;
        logic     perr;
        payload_t payload;
    } deq_rsp_t;

    // Raw debug access to any word of the array
    typedef struct packed {
        logic     wr;
        logic     rd;
        rf_addr_t addr;
        rf_word_t data;
    } cfg_cmd_t;

endpackage

//--- verilog/qs_rf_128x35.sv
/*
 * Two-port register file, 128 words of 35 bits
 * One write port and one read port with a registered output,
 * functional ports only
 */

`timescale 1ns/100ps

module qs_rf_128x35
    import qs_mem_pkg::*;
(
     input  logic     clk
    ,input  rf_wr_t   wr
    ,input  rf_rd_t   rd
    ,output rf_word_t rdata
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // The array has no reset, contents are unknown until written
    rf_word_t mem [RF_DEPTH];

    // Write takes effect at the clock edge of the cycle it is presented
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // Data shows up one cycle after the read enable
    // A read of the address being written in the same cycle returns the old word
    // Without a read enable the output keeps the last word read
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdata <= mem[rd.addr];
        end
    end

endmodule

//--- verilog/qs_mem_arbiter.sv
/*
 * Memory port arbiter
 * Shares the array write and read ports between the queue agents and
 * debug access, queue traffic always first, and steers read data back
 */

`timescale 1ns/100ps

module qs_mem_arbiter
    import qs_mem_pkg::*;
(
     input  logic     clk
    ,input  logic     rst_n

    ,input  rf_wr_t   enq_wr
    ,input  rf_rd_t   deq_rd

    ,input  rf_wr_t   cfg_wr_req
    ,input  rf_rd_t   cfg_rd_req
    ,output logic     cfg_wr_gnt
    ,output logic     cfg_rd_gnt

    ,output rf_wr_t   mem_wr
    ,output rf_rd_t   mem_rd
    ,input  rf_word_t mem_rdata

    ,output rf_word_t deq_rdata
    ,output logic     deq_rdata_valid
    ,output rf_word_t cfg_rdata
    ,output logic     cfg_rdata_valid
);

    // Read issued last cycle, one flag per requester
    logic deq_rd_q;
    logic cfg_rd_q;

    // ------------------------------------------------------------------------
    // Grant and port muxing
    // ------------------------------------------------------------------------

    // Debug access only gets a port when the queue agent leaves it idle
    assign cfg_wr_gnt = cfg_wr_req.en && !enq_wr.en;
    assign cfg_rd_gnt = cfg_rd_req.en && !deq_rd.en;

    always_comb begin
        if (enq_wr.en) begin
            mem_wr = enq_wr;
        end else begin
            mem_wr = cfg_wr_req;
        end
    end

    always_comb begin
        if (deq_rd.en) begin
            mem_rd = deq_rd;
        end else begin
            mem_rd = cfg_rd_req;
        end
    end

    // ------------------------------------------------------------------------
    // Read data steering
    // ------------------------------------------------------------------------

    // Owner of the read in flight, the array answers one cycle after the grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            deq_rd_q <= 1'b0;
            cfg_rd_q <= 1'b0;
        end else begin
            deq_rd_q <= deq_rd.en;
            cfg_rd_q <= cfg_rd_gnt;
        end
    end

    // Both owners see the same data bus, only the valid pulse tells whose it is
    assign deq_rdata       = mem_rdata;
    assign cfg_rdata       = mem_rdata;
    assign deq_rdata_valid = deq_rd_q;
    assign cfg_rdata_valid = cfg_rd_q;

endmodule

//--- verilog/qs_enq_agent.sv
/*
 * Enqueue agent
 * Keeps the tail pointer of each queue, drops enqueues to a full queue
 * and writes accepted payloads into the array with even parity
 */

`timescale 1ns/100ps

module qs_enq_agent
    import qs_mem_pkg::*;
    import qs_queue_pkg::*;
(
     input  logic                     clk
    ,input  logic                     rst_n

    ,input  enq_cmd_t                 enq
    ,input  qptr_t [NUM_QUEUES-1:0]   head_ptrs
    ,output qptr_t [NUM_QUEUES-1:0]   tail_ptrs

    ,output rf_wr_t                   enq_wr
    ,output logic                     enq_drop
);

    qptr_t [NUM_QUEUES-1:0] tail_q;

    // Pointers of the addressed queue
    qptr_t tail_sel;
    qptr_t head_sel;

    logic full;
    logic accept;

    // ------------------------------------------------------------------------
    // Fullness
    // ------------------------------------------------------------------------

    assign tail_sel = tail_q[enq.qid];
    assign head_sel = head_ptrs[enq.qid];

    // Judged on start-of-cycle pointers, so a dequeue in this same cycle
    // does not make room for this enqueue
    assign full   = qptr_t'(tail_sel - head_sel) == qptr_t'(QUEUE_DEPTH);
    assign accept = enq.valid && !full;

    // ------------------------------------------------------------------------
    // Array write
    // ------------------------------------------------------------------------

    // The parity bit makes the number of ones in the word even
    always_comb begin
        enq_wr.en                        = accept;
        enq_wr.addr                      = {enq.qid, tail_sel[SLOT_W-1:0]};
        enq_wr.data[PARITY_BIT]          = ^enq.payload;
        enq_wr.data[PARITY_BIT-1:0]      = enq.payload;
    end

    // ------------------------------------------------------------------------
    // Tail pointers and drop flag
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_q   <= '0;
            enq_drop <= 1'b0;
        end else begin
            if (accept) begin
                tail_q[enq.qid] <= qptr_t'(tail_sel + 1'b1);
            end
            // Reported in the cycle after the dropped strobe
            enq_drop <= enq.valid && full;
        end
    end

    assign tail_ptrs = tail_q;

endmodule

//--- verilog/qs_deq_agent.sv
/*
 * Dequeue agent
 * Keeps the head pointer of each queue, reads the head entry of a
 * non-empty queue, checks its parity and answers every dequeue strobe
 */

`timescale 1ns/100ps

module qs_deq_agent
    import qs_mem_pkg::*;
    import qs_queue_pkg::*;
(
     input  logic                     clk
    ,input  logic                     rst_n

    ,input  deq_cmd_t                 deq
    ,input  qptr_t [NUM_QUEUES-1:0]   tail_ptrs
    ,output qptr_t [NUM_QUEUES-1:0]   head_ptrs

    ,output rf_rd_t                   deq_rd
    ,input  rf_word_t                 rdata
    ,input  logic                     rdata_valid

    ,output deq_rsp_t                 deq_rsp
);

    qptr_t [NUM_QUEUES-1:0] head_q;

    // Pointers of the addressed queue
    qptr_t head_sel;
    qptr_t tail_sel;

    logic empty;
    logic rd_ok;

    // Empty answer held back one cycle to line up with array data
    logic empty_q;

    // ------------------------------------------------------------------------
    // Emptiness and read request
    // ------------------------------------------------------------------------

    assign head_sel = head_q[deq.qid];
    assign tail_sel = tail_ptrs[deq.qid];

    // Equal pointers including the wrap bit mean nothing is stored
    assign empty = head_sel == tail_sel;
    assign rd_ok = deq.valid && !empty;

    always_comb begin
        deq_rd.en   = rd_ok;
        deq_rd.addr = {deq.qid, head_sel[SLOT_W-1:0]};
    end

    // ------------------------------------------------------------------------
    // Head pointers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            empty_q <= 1'b0;
        end else begin
            if (rd_ok) begin
                head_q[deq.qid] <= qptr_t'(head_sel + 1'b1);
            end
            empty_q <= deq.valid && empty;
        end
    end

    assign head_ptrs = head_q;

    // ------------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------------

    // The array output register supplies the cycle of latency for data,
    // empty_q supplies it for empty answers
    // An odd number of ones across the stored word is a parity error
    always_comb begin
        deq_rsp.valid   = rdata_valid || empty_q;
        deq_rsp.empty   = empty_q;
        deq_rsp.perr    = rdata_valid && (^rdata);
        deq_rsp.payload = rdata[PARITY_BIT-1:0];
    end

endmodule

//--- verilog/qs_cfg_access.sv
/*
 * Debug access to the raw array
 * Latches one read or write, holds it until the arbiter grants the port,
 * then pulses done with the read word where there is one
 */

`timescale 1ns/100ps

module qs_cfg_access
    import qs_mem_pkg::*;
    import qs_queue_pkg::*;
(
     input  logic     clk
    ,input  logic     rst_n

    ,input  cfg_cmd_t cfg
    ,output logic     cfg_busy
    ,output logic     cfg_done
    ,output rf_word_t cfg_rdata

    ,output rf_wr_t   wr_req
    ,output rf_rd_t   rd_req
    ,input  logic     wr_gnt
    ,input  logic     rd_gnt
    ,input  rf_word_t rdata
    ,input  logic     rdata_valid
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        WAIT_DATA
    } cfg_state_e;

    cfg_state_e state_q;

    // Latched command, a write wins when both wr and rd are set
    logic     is_wr_q;
    rf_addr_t addr_q;
    rf_word_t data_q;

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            is_wr_q  <= 1'b0;
            cfg_done <= 1'b0;
        end else begin
            cfg_done <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cfg.wr || cfg.rd) begin
                        is_wr_q <= cfg.wr;
                        state_q <= WAIT_GNT;
                    end
                end
                WAIT_GNT: begin
                    // A granted write is done at this edge
                    if (is_wr_q && wr_gnt) begin
                        cfg_done <= 1'b1;
                        state_q  <= IDLE;
                    end else if (!is_wr_q && rd_gnt) begin
                        state_q <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (rdata_valid) begin
                        cfg_done <= 1'b1;
                        state_q  <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Address, data and read result are plain payload registers
    always_ff @(posedge clk) begin
        if (state_q == IDLE && (cfg.wr || cfg.rd)) begin
            addr_q <= cfg.addr;
            data_q <= cfg.data;
        end
        if (state_q == WAIT_DATA && rdata_valid) begin
            cfg_rdata <= rdata;
        end
    end

    // ------------------------------------------------------------------------
    // Requests to the arbiter
    // ------------------------------------------------------------------------

    assign cfg_busy = state_q != IDLE;

    always_comb begin
        wr_req.en   = (state_q == WAIT_GNT) && is_wr_q;
        wr_req.addr = addr_q;
        wr_req.data = data_q;
        rd_req.en   = (state_q == WAIT_GNT) && !is_wr_q;
        rd_req.addr = addr_q;
    end

endmodule

//--- verilog/qs_top.sv
/*
 * Queue storage subsystem
 * Four 32-entry queues and raw debug access over one shared 128x35 array
 */

`timescale 1ns/100ps

module qs_top
    import qs_mem_pkg::*;
    import qs_queue_pkg::*;
(
     input  logic     clk
    ,input  logic     rst_n

    ,input  enq_cmd_t enq
    ,output logic     enq_drop

    ,input  deq_cmd_t deq
    ,output deq_rsp_t deq_rsp

    ,input  cfg_cmd_t cfg
    ,output logic     cfg_busy
    ,output logic     cfg_done
    ,output rf_word_t cfg_rdata
);

    // Pointer exchange between the queue agents
    qptr_t [NUM_QUEUES-1:0] head_ptrs;
    qptr_t [NUM_QUEUES-1:0] tail_ptrs;

    // Requests into the arbiter
    rf_wr_t   enq_wr;
    rf_rd_t   deq_rd;
    rf_wr_t   cfg_wr_req;
    rf_rd_t   cfg_rd_req;
    logic     cfg_wr_gnt;
    logic     cfg_rd_gnt;

    // Array side
    rf_wr_t   mem_wr;
    rf_rd_t   mem_rd;
    rf_word_t mem_rdata;

    // Steered read data
    rf_word_t deq_rdata;
    logic     deq_rdata_valid;
    rf_word_t arb_cfg_rdata;
    logic     cfg_rdata_valid;

    // ------------------------------------------------------------------------
    // Queue agents
    // ------------------------------------------------------------------------

    qs_enq_agent i_enq (
         .clk         (clk)
        ,.rst_n       (rst_n)
        ,.enq         (enq)
        ,.head_ptrs   (head_ptrs)
        ,.tail_ptrs   (tail_ptrs)
        ,.enq_wr      (enq_wr)
        ,.enq_drop    (enq_drop)
    );

    qs_deq_agent i_deq (
         .clk         (clk)
        ,.rst_n       (rst_n)
        ,.deq         (deq)
        ,.tail_ptrs   (tail_ptrs)
        ,.head_ptrs   (head_ptrs)
        ,.deq_rd      (deq_rd)
        ,.rdata       (deq_rdata)
        ,.rdata_valid (deq_rdata_valid)
        ,.deq_rsp     (deq_rsp)
    );

    // ------------------------------------------------------------------------
    // Debug access, arbiter and array
    // ------------------------------------------------------------------------

    qs_cfg_access i_cfg (
         .clk         (clk)
        ,.rst_n       (rst_n)
        ,.cfg         (cfg)
        ,.cfg_busy    (cfg_busy)
        ,.cfg_done    (cfg_done)
        ,.cfg_rdata   (cfg_rdata)
        ,.wr_req      (cfg_wr_req)
        ,.rd_req      (cfg_rd_req)
        ,.wr_gnt      (cfg_wr_gnt)
        ,.rd_gnt      (cfg_rd_gnt)
        ,.rdata       (arb_cfg_rdata)
        ,.rdata_valid (cfg_rdata_valid)
    );

    qs_mem_arbiter i_arb (
         .clk             (clk)
        ,.rst_n           (rst_n)
        ,.enq_wr          (enq_wr)
        ,.deq_rd          (deq_rd)
        ,.cfg_wr_req      (cfg_wr_req)
        ,.cfg_rd_req      (cfg_rd_req)
        ,.cfg_wr_gnt      (cfg_wr_gnt)
        ,.cfg_rd_gnt      (cfg_rd_gnt)
        ,.mem_wr          (mem_wr)
        ,.mem_rd          (mem_rd)
        ,.mem_rdata       (mem_rdata)
        ,.deq_rdata       (deq_rdata)
        ,.deq_rdata_valid (deq_rdata_valid)
        ,.cfg_rdata       (arb_cfg_rdata)
        ,.cfg_rdata_valid (cfg_rdata_valid)
    );

    qs_rf_128x35 i_rf (
         .clk   (clk)
        ,.wr    (mem_wr)
        ,.rd    (mem_rd)
        ,.rdata (mem_rdata)
    );

endmodule

//--- tests/qs_tb_chk.sv
/*
 * Arbiter checks
 * A debug request waits unchanged on its port until it is granted,
 * and it leaves the port in the cycle after the grant
 */

`timescale 1ns/100ps

module qs_tb_chk
    import qs_mem_pkg::*;
(
     input logic   clk
    ,input logic   rst_n
    ,input rf_wr_t cfg_wr_req
    ,input rf_rd_t cfg_rd_req
    ,input logic   cfg_wr_gnt
    ,input logic   cfg_rd_gnt
);

    // A debug write held back by enqueue traffic stays presented as it was
    wr_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_wr_req.en && !cfg_wr_gnt) |=> (cfg_wr_req.en && $stable(cfg_wr_req)))
        else $error("debug write request changed before its grant");

    // A debug read held back by dequeue traffic stays presented as it was
    rd_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_rd_req.en && !cfg_rd_gnt) |=> (cfg_rd_req.en && $stable(cfg_rd_req)))
        else $error("debug read request changed before its grant");

    // Each debug access takes its port exactly once
    gnt_once: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_wr_gnt || cfg_rd_gnt) |=> (!cfg_wr_req.en && !cfg_rd_req.en))
        else $error("debug request still raised in the cycle after its grant");

endmodule

bind qs_mem_arbiter qs_tb_chk i_chk (
     .clk        (clk)
    ,.rst_n      (rst_n)
    ,.cfg_wr_req (cfg_wr_req)
    ,.cfg_rd_req (cfg_rd_req)
    ,.cfg_wr_gnt (cfg_wr_gnt)
    ,.cfg_rd_gnt (cfg_rd_gnt)
);

//--- tests/qs_tb.sv
/*
 * Queue storage testbench
 * Directed tests against a four-queue model with LFSR payloads,
 * covering reset, FIFO order, full queues, debug access and parity errors
 */

`timescale 1ns/100ps

module qs_tb
    import qs_mem_pkg::*;
    import qs_queue_pkg::*;
();

    localparam int CLK_PERIOD = 20;

    // Operations per test, each allowed 50 cycles by the watchdog
    localparam int NUM_OPS = 4 + 48 + 70 + 40 + 12;

    logic     clk = 1'b0;
    logic     rst_n;
    enq_cmd_t enq;
    logic     enq_drop;
    deq_cmd_t deq;
    deq_rsp_t deq_rsp;
    cfg_cmd_t cfg;
    logic     cfg_busy;
    logic     cfg_done;
    rf_word_t cfg_rdata;

    // Queue model, words kept by slot so debug writes can patch them
    rf_word_t model_word  [NUM_QUEUES][QUEUE_DEPTH];
    int       model_count [NUM_QUEUES];
    int       model_tail  [NUM_QUEUES];

    logic [31:0] lfsr_state;
    string       test_name;
    logic        run_complete;
    logic        fail_printed;

    qs_top i_dut (
         .clk       (clk)
        ,.rst_n     (rst_n)
        ,.enq       (enq)
        ,.enq_drop  (enq_drop)
        ,.deq       (deq)
        ,.deq_rsp   (deq_rsp)
        ,.cfg       (cfg)
        ,.cfg_busy  (cfg_busy)
        ,.cfg_done  (cfg_done)
        ,.cfg_rdata (cfg_rdata)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    // One LFSR step for every bit handed out
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Stored words carry a parity bit that makes the count of ones even
    function automatic rf_word_t even_parity_word(input payload_t p);
        return {^p, p};
    endfunction

    // Slot of entry k counted from the head of queue q
    function automatic int entry_slot(input int q, input int k);
        return (model_tail[q] - model_count[q] + k + QUEUE_DEPTH) % QUEUE_DEPTH;
    endfunction

    task automatic stop_run();
        fail_printed = 1'b1;
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            stop_run();
        end
    endtask

    // Drives one cycle from a falling edge and checks its answers at the next one
    // Both verdicts are taken from the model before it is updated
    task automatic clock_step(input logic do_enq, input qid_t eq, input payload_t ep,
                              input logic do_deq, input qid_t dq);
        logic     exp_drop;
        logic     exp_empty;
        rf_word_t exp_word;
        exp_drop  = do_enq && (model_count[eq] == QUEUE_DEPTH);
        exp_empty = model_count[dq] == 0;
        exp_word  = model_word[dq][entry_slot(dq, 0)];
        enq.valid   = do_enq;
        enq.qid     = eq;
        enq.payload = ep;
        deq.valid   = do_deq;
        deq.qid     = dq;
        if (do_enq && !exp_drop) begin
            model_word[eq][model_tail[eq]] = even_parity_word(ep);
            model_tail[eq] = (model_tail[eq] + 1) % QUEUE_DEPTH;
            model_count[eq]++;
        end
        if (do_deq && !exp_empty) begin
            model_count[dq]--;
        end
        @(negedge clk);
        enq = '0;
        deq = '0;
        cfg = '0;
        compare("enq_drop", 64'(exp_drop), 64'(enq_drop));
        compare("deq_rsp.valid", 64'(do_deq), 64'(deq_rsp.valid));
        if (do_deq) begin
            compare("deq_rsp.empty", 64'(exp_empty), 64'(deq_rsp.empty));
            // Payload and perr only mean something for a data answer
            if (!exp_empty) begin
                compare("deq_rsp.payload", 64'(exp_word[PARITY_BIT-1:0]),
                        64'(deq_rsp.payload));
                compare("deq_rsp.perr", 64'(^exp_word), 64'(deq_rsp.perr));
            end
        end
    endtask

    task automatic drain_queue(input qid_t q);
        while (model_count[q] > 0) begin
            clock_step(1'b0, '0, '0, 1'b1, q);
        end
    endtask

    // Presented for one cycle, the next clock_step clears it
    task automatic start_cfg(input logic wr, input logic rd, input rf_addr_t addr,
                             input rf_word_t data);
        compare("cfg_busy before command", 64'd0, 64'(cfg_busy));
        cfg.wr   = wr;
        cfg.rd   = rd;
        cfg.addr = addr;
        cfg.data = data;
    endtask

    task automatic wait_cfg_done(input int limit);
        int n;
        n = 0;
        while (!cfg_done) begin
            if (n == limit) begin
                $display("cfg_done did not arrive within %0d idle cycles", limit);
                stop_run();
            end else begin
                clock_step(1'b0, '0, '0, 1'b0, '0);
                n++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic after_reset();
        test_name = "after_reset";
        compare("enq_drop", 64'd0, 64'(enq_drop));
        compare("deq_rsp.valid", 64'd0, 64'(deq_rsp.valid));
        compare("cfg_busy", 64'd0, 64'(cfg_busy));
        compare("cfg_done", 64'd0, 64'(cfg_done));
        for (int q = 0; q < NUM_QUEUES; q++) begin
            clock_step(1'b0, '0, '0, 1'b1, qid_t'(q));
        end
    endtask

    task automatic fifo_order();
        qid_t     eq;
        payload_t ep;
        logic     dv;
        qid_t     dq;
        test_name = "fifo_order";
        for (int i = 0; i < 24; i++) begin
            eq = qid_t'(rand_bits(2));
            ep = payload_t'(rand_bits(34));
            dv = rand_bits(1) == 64'd1;
            dq = qid_t'(rand_bits(2));
            clock_step(1'b1, eq, ep, dv, dq);
        end
        // Draining runs dequeues back to back
        for (int q = 0; q < NUM_QUEUES; q++) begin
            drain_queue(qid_t'(q));
        end
    endtask

    task automatic fill_and_drain();
        test_name = "fill_and_drain";
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            clock_step(1'b1, 2'd0, payload_t'(rand_bits(34)), 1'b0, '0);
        end
        // Still full at the start of the cycle so the enqueue is dropped
        clock_step(1'b1, 2'd0, payload_t'(rand_bits(34)), 1'b1, 2'd0);
        clock_step(1'b1, 2'd0, payload_t'(rand_bits(34)), 1'b0, '0);
        drain_queue(2'd0);
        // Empty at the start of the cycle, the new entry is seen one cycle later
        clock_step(1'b1, 2'd0, payload_t'(rand_bits(34)), 1'b1, 2'd0);
        clock_step(1'b0, '0, '0, 1'b1, 2'd0);
        clock_step(1'b0, '0, '0, 1'b1, 2'd0);
    endtask

    task automatic cfg_under_traffic();
        rf_addr_t addr;
        rf_word_t word;
        test_name = "cfg_under_traffic";
        // Queue 3 is empty here, so its region is free for a raw word
        addr = {2'd3, 5'd17};
        word = rf_word_t'(rand_bits(35));
        start_cfg(1'b1, 1'b0, addr, word);
        for (int i = 0; i < 8; i++) begin
            clock_step(1'b1, 2'd1, payload_t'(rand_bits(34)), 1'b0, '0);
            compare("cfg_busy during writes", 64'd1, 64'(cfg_busy));
            compare("cfg_done during writes", 64'd0, 64'(cfg_done));
        end
        wait_cfg_done(20);
        clock_step(1'b0, '0, '0, 1'b0, '0);
        // Dequeues from queue 1 keep the read port taken every cycle
        start_cfg(1'b0, 1'b1, addr, '0);
        for (int i = 0; i < 8; i++) begin
            clock_step(1'b1, 2'd1, payload_t'(rand_bits(34)), 1'b1, 2'd1);
            compare("cfg_busy during reads", 64'd1, 64'(cfg_busy));
            compare("cfg_done during reads", 64'd0, 64'(cfg_done));
        end
        wait_cfg_done(20);
        compare("cfg_rdata", 64'(word), 64'(cfg_rdata));
        drain_queue(2'd1);
    endtask

    task automatic parity_injection();
        payload_t p;
        rf_word_t bad;
        int       slot;
        test_name = "parity_injection";
        for (int i = 0; i < 4; i++) begin
            clock_step(1'b1, 2'd2, payload_t'(rand_bits(34)), 1'b0, '0);
        end
        // Overwrite the second entry with an odd count of ones
        slot = entry_slot(2, 1);
        p    = payload_t'(rand_bits(34));
        bad  = {~(^p), p};
        start_cfg(1'b1, 1'b0, {2'd2, 5'(slot)}, bad);
        clock_step(1'b0, '0, '0, 1'b0, '0);
        wait_cfg_done(20);
        model_word[2][slot] = bad;
        drain_queue(2'd2);
    endtask

    // ------------------------------------------------------------------------
    // Sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        rst_n        = 1'b0;
        enq          = '0;
        deq          = '0;
        cfg          = '0;
        lfsr_state   = 32'hdb2db5ab;
        run_complete = 1'b0;
        fail_printed = 1'b0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            model_count[q] = 0;
            model_tail[q]  = 0;
            for (int s = 0; s < QUEUE_DEPTH; s++) begin
                model_word[q][s] = '0;
            end
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        after_reset();
        fifo_order();
        fill_and_drain();
        cfg_under_traffic();
        parity_injection();
        run_complete = 1'b1;
        $display("Test OK");
        $finish;
    end

    initial begin
        #(NUM_OPS * 50 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles", NUM_OPS * 50);
        stop_run();
    end

    // A run cut short by a failed concurrent assertion ends here
    final begin
        if (!run_complete && !fail_printed) begin
            $display("Test FAILED");
        end
    end

endmodule

//--- files.f
verilog/qs_mem_pkg.sv
verilog/qs_queue_pkg.sv
verilog/qs_rf_128x35.sv
verilog/qs_mem_arbiter.sv
verilog/qs_enq_agent.sv
verilog/qs_deq_agent.sv
verilog/qs_cfg_access.sv
verilog/qs_top.sv
tests/qs_tb_chk.sv
tests/qs_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the queue storage testbench with Verilator.
# The result is taken from the pass message in sim.log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module qs_tb -f files.f -o qs_sim

# The simulator exits non-zero on a failure, the log search decides
./obj_dir/qs_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
    exit 0
else
    exit 1
fi
